// ==== rtl/msx_pkg.sv ====
package msx_pkg;

   // Kind of access seen on the CPU bus
   // Held from the request pulse until the strobes go away
   typedef enum logic [2:0] {
      CYCLE_IDLE,
      CYCLE_MEM_RD,
      CYCLE_MEM_WR,
      CYCLE_IO_RD,
      CYCLE_IO_WR
   } bus_cycle_t;

   // Primary slot register
   localparam logic [7:0] PORT_SLOT_SEL = 8'hA8;

   // PPI port C, key click on bit 7
   localparam logic [7:0] PORT_PPI_C = 8'hAA;

   // First mapper port, FCh to FFh cover pages 0 to 3
   localparam logic [7:0] PORT_MAPPER_BASE = 8'hFC;

   // Slot holding the mapped RAM
   localparam logic [1:0] RAM_SLOT = 2'd3;

   // Slot holding the BIOS ROM
   localparam logic [1:0] ROM_SLOT = 2'd0;

endpackage

// ==== rtl/cpu_bus_decode.sv ====
`timescale 1ns/1ns

module cpu_bus_decode #(
   parameter int M1_WAIT = 1
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               cpu_ce,
   input  logic               m1_n,
   input  logic               mreq_n,
   input  logic               iorq_n,
   input  logic               rd_n,
   input  logic               wr_n,
   input  logic [7:0]         addr,
   input  logic               ext_wait,
   output logic               req,
   output msx_pkg::bus_cycle_t cycle,
   output logic [7:0]         io_port,
   output logic               wait_n
);

   import msx_pkg::*;

   // Bus access in progress, memory or I/O with a read or write strobe
   logic       access_on;
   // Set once the current access has produced its request
   logic       iack;
   // Fresh access this clock, not yet acknowledged
   logic       access_new;
   bus_cycle_t cycle_next;

   // M1 edge detect and wait counter
   logic       last_m1;
   logic [2:0] wait_count;

   assign access_on  = (~mreq_n | ~iorq_n) & (~rd_n | ~wr_n);
   assign access_new = access_on & ~iack;

   // Classify from the strobes
   // I/O takes priority, read wins over write
   always_comb begin
      if (~iorq_n) begin
         cycle_next = rd_n ? CYCLE_IO_WR : CYCLE_IO_RD;
      end else begin
         cycle_next = rd_n ? CYCLE_MEM_WR : CYCLE_MEM_RD;
      end
   end

   // One request per access
   // iack only drops once both mreq_n and iorq_n are back high
   always_ff @(posedge clk) begin
      if (reset) begin
         iack  <= 1'b0;
         req   <= 1'b0;
         cycle <= CYCLE_IDLE;
      end else begin
         req <= 1'b0;
         if (mreq_n && iorq_n) begin
            iack  <= 1'b0;
            cycle <= CYCLE_IDLE;
         end else if (access_new) begin
            iack  <= 1'b1;
            req   <= 1'b1;
            cycle <= cycle_next;
         end
      end
   end

   // Low address byte latched with the request, I/O port number
   always_ff @(posedge clk) begin
      if (access_new) begin
         io_port <= addr;
      end
   end

   // M1 wait states
   // Counter loads on M1 going active, then drains once per cpu_ce
   always_ff @(posedge clk) begin
      if (reset) begin
         last_m1    <= 1'b0;
         wait_count <= 3'd0;
      end else if (cpu_ce) begin
         last_m1 <= ~m1_n;
         if (~m1_n && ~last_m1) begin
            wait_count <= 3'(M1_WAIT);
         end else if (wait_count != 3'd0) begin
            wait_count <= wait_count - 3'd1;
         end
      end
   end

   // External devices can stretch any cycle
   assign wait_n = (wait_count == 3'd0) && ~ext_wait;

endmodule

// ==== rtl/slot_select.sv ====
`timescale 1ns/1ns

module slot_select #(
   parameter int MEM_ADDR_W = 22
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  req,
   input  msx_pkg::bus_cycle_t   cycle,
   input  logic [7:0]            io_port,
   input  logic [7:0]            cpu_dout,
   input  logic [15:0]           addr,
   input  logic                  mreq_n,
   output logic [MEM_ADDR_W-1:0] mem_addr,
   output logic                  rom_ce,
   output logic                  ram_ce,
   output logic                  slot_data_rq,
   output logic [7:0]            io_data,
   output logic                  io_hit
);

   import msx_pkg::*;

   // Primary slot register, two bits per page
   logic [7:0] slot_reg;
   // Mapper page per 16 KB page
   logic [7:0] mapper_reg [4];

   logic       io_wr;
   logic       slot_port;
   logic       mapper_port;
   logic [1:0] page;
   logic [1:0] page_slot;
   logic [7:0] page_map;

   // Port decode, valid while cycle is held
   assign slot_port   = (io_port == PORT_SLOT_SEL);
   assign mapper_port = (io_port[7:2] == PORT_MAPPER_BASE[7:2]);
   assign io_wr       = req && (cycle == CYCLE_IO_WR);

   // Register writes on the request pulse
   always_ff @(posedge clk) begin
      if (reset) begin
         slot_reg <= 8'h00;
         for (int i = 0; i < 4; i++) begin
            // Pages 0..3 start at mapper pages 3..0
            mapper_reg[i] <= 8'(3 - i);
         end
      end else if (io_wr) begin
         if (slot_port) begin
            slot_reg <= cpu_dout;
         end
         if (mapper_port) begin
            mapper_reg[io_port[1:0]] <= cpu_dout;
         end
      end
   end

   // Page from the top two address bits
   assign page      = addr[15:14];
   assign page_slot = slot_reg[2*page +: 2];
   assign page_map  = mapper_reg[page];

   // External memory address
   // RAM goes through the mapper, everything else is flat
   always_comb begin
      if (page_slot == RAM_SLOT) begin
         mem_addr = MEM_ADDR_W'({page_map, addr[13:0]});
      end else begin
         mem_addr = MEM_ADDR_W'(addr);
      end
   end

   // Chip enables only during memory cycles
   assign rom_ce = ~mreq_n && (page_slot == ROM_SLOT);
   assign ram_ce = ~mreq_n && (page_slot == RAM_SLOT);

   // Slots 1 and 2 are empty and float high
   assign slot_data_rq = rom_ce | ram_ce;

   // Readback of slot and mapper registers
   assign io_hit = (cycle == CYCLE_IO_RD) && (slot_port || mapper_port);

   always_comb begin
      if (slot_port) begin
         io_data = slot_reg;
      end else begin
         io_data = mapper_reg[io_port[1:0]];
      end
   end

endmodule

// ==== rtl/cpu_data_mux.sv ====
`timescale 1ns/1ns

module cpu_data_mux (
   input  logic       rd_n,
   input  logic       io_hit,
   input  logic [7:0] io_data,
   input  logic       slot_data_rq,
   input  logic [7:0] mem_dout,
   output logic [7:0] cpu_din
);

   // Read data back to the CPU
   // Idle bus and unclaimed reads return FFh
   always_comb begin
      if (rd_n) begin
         // No read strobe
         cpu_din = 8'hFF;
      end else if (io_hit) begin
         // Internal I/O registers first
         cpu_din = io_data;
      end else if (slot_data_rq) begin
         // ROM or RAM slot selected
         cpu_din = mem_dout;
      end else begin
         // Empty slot or unknown port
         cpu_din = 8'hFF;
      end
   end

endmodule

// ==== rtl/audio_mix.sv ====
`timescale 1ns/1ns

module audio_mix (
   input  logic                clk,
   input  logic                reset,
   input  logic                req,
   input  msx_pkg::bus_cycle_t cycle,
   input  logic [7:0]          io_port,
   input  logic [7:0]          cpu_dout,
   input  logic                tape_in,
   input  logic signed [15:0]  device_sound,
   output logic [15:0]         audio
);

   import msx_pkg::*;

   logic               key_click;
   // Key click worth 32 plus tape worth 16, already times 16
   logic        [9:0]  sys_sound;
   logic signed [16:0] mix_sum;
   logic        [15:0] mix_sat;

   // Key click bit from PPI port C writes
   always_ff @(posedge clk) begin
      if (reset) begin
         key_click <= 1'b0;
      end else if (req && (cycle == CYCLE_IO_WR) && (io_port == PORT_PPI_C)) begin
         key_click <= cpu_dout[7];
      end
   end

   assign sys_sound = {key_click, tape_in, 8'h00};

   // 17-bit sum with sign extension of the device sound
   assign mix_sum = {device_sound[15], device_sound} + $signed({7'd0, sys_sound});

   // Clip to 15 bits, then shift up one
   always_comb begin
      if (mix_sum > 17'sd16383) begin
         mix_sat = 16'h7FFE;
      end else if (mix_sum < -17'sd16384) begin
         mix_sat = 16'h8000;
      end else begin
         mix_sat = {mix_sum[14:0], 1'b0};
      end
   end

   // One clock of latency on the output sample
   always_ff @(posedge clk) begin
      audio <= mix_sat;
   end

endmodule

// ==== rtl/msx_core.sv ====
`timescale 1ns/1ns

module msx_core #(
   parameter int M1_WAIT    = 1,
   parameter int MEM_ADDR_W = 22
) (
   input  logic                  clk,
   input  logic                  reset,
   // CPU bus
   input  logic                  cpu_ce,
   input  logic                  m1_n,
   input  logic                  mreq_n,
   input  logic                  iorq_n,
   input  logic                  rd_n,
   input  logic                  wr_n,
   input  logic [15:0]           addr,
   input  logic [7:0]            cpu_dout,
   output logic [7:0]            cpu_din,
   output logic                  wait_n,
   // External memory
   output logic [MEM_ADDR_W-1:0] mem_addr,
   output logic                  rom_ce,
   output logic                  ram_ce,
   input  logic [7:0]            mem_dout,
   // Sound and misc
   input  logic                  tape_in,
   input  logic                  ext_wait,
   input  logic signed [15:0]    device_sound,
   output logic [15:0]           audio
);

   import msx_pkg::*;

   // Decoded bus, shared by the register blocks
   logic       req;
   bus_cycle_t cycle;
   logic [7:0] io_port;

   // Slot side read data
   logic       slot_data_rq;
   logic [7:0] io_data;
   logic       io_hit;

   cpu_bus_decode #(
      .M1_WAIT (M1_WAIT)
   ) cpu_bus_decode_i (
      .clk      (clk),
      .reset    (reset),
      .cpu_ce   (cpu_ce),
      .m1_n     (m1_n),
      .mreq_n   (mreq_n),
      .iorq_n   (iorq_n),
      .rd_n     (rd_n),
      .wr_n     (wr_n),
      .addr     (addr[7:0]),
      .ext_wait (ext_wait),
      .req      (req),
      .cycle    (cycle),
      .io_port  (io_port),
      .wait_n   (wait_n)
   );

   slot_select #(
      .MEM_ADDR_W (MEM_ADDR_W)
   ) slot_select_i (
      .clk          (clk),
      .reset        (reset),
      .req          (req),
      .cycle        (cycle),
      .io_port      (io_port),
      .cpu_dout     (cpu_dout),
      .addr         (addr),
      .mreq_n       (mreq_n),
      .mem_addr     (mem_addr),
      .rom_ce       (rom_ce),
      .ram_ce       (ram_ce),
      .slot_data_rq (slot_data_rq),
      .io_data      (io_data),
      .io_hit       (io_hit)
   );

   // Data back to the CPU
   cpu_data_mux cpu_data_mux_i (
      .rd_n         (rd_n),
      .io_hit       (io_hit),
      .io_data      (io_data),
      .slot_data_rq (slot_data_rq),
      .mem_dout     (mem_dout),
      .cpu_din      (cpu_din)
   );

   audio_mix audio_mix_i (
      .clk          (clk),
      .reset        (reset),
      .req          (req),
      .cycle        (cycle),
      .io_port      (io_port),
      .cpu_dout     (cpu_dout),
      .tape_in      (tape_in),
      .device_sound (device_sound),
      .audio        (audio)
   );

endmodule

// ==== tests/msx_core_sva.sv ====
`timescale 1ns/1ns

module msx_core_sva (
   input logic clk,
   input logic reset,
   input logic m1_n,
   input logic mreq_n,
   input logic iorq_n,
   input logic ext_wait,
   input logic req,
   input logic wait_n
);

   // Request already given in the current access
   logic req_seen;
   // Any M1 since reset
   logic m1_seen;

   always_ff @(posedge clk) begin
      if (reset || (mreq_n && iorq_n)) begin
         req_seen <= 1'b0;
      end else if (req) begin
         req_seen <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         m1_seen <= 1'b0;
      end else if (~m1_n) begin
         m1_seen <= 1'b1;
      end
   end

   // Single clock pulse
   req_pulse: assert property (@(posedge clk) disable iff (reset) req |=> !req)
      else $error("req high for two cycles in a row");

   // One request until both strobes are released
   req_once: assert property (@(posedge clk) disable iff (reset) req |-> !req_seen)
      else $error("second req inside one bus access");

   // No M1 wait states before the first fetch
   wait_quiet: assert property (@(posedge clk) disable iff (reset)
      (!m1_seen && !ext_wait) |-> wait_n)
      else $error("wait_n low before any M1 cycle");

endmodule

bind cpu_bus_decode msx_core_sva msx_core_sva_i (
   .clk      (clk),
   .reset    (reset),
   .m1_n     (m1_n),
   .mreq_n   (mreq_n),
   .iorq_n   (iorq_n),
   .ext_wait (ext_wait),
   .req      (req),
   .wait_n   (wait_n)
);

// ==== tests/msx_core_tb.sv ====
`timescale 1ns/1ns

module msx_core_tb;

   import msx_pkg::*;

   localparam int M1_WAIT    = 2;
   localparam int MEM_ADDR_W = 22;
   localparam int HOLD_CE    = 2;
   localparam int SLOT_ITER  = 8;
   localparam int MAP_ITER   = 3;
   localparam int AUDIO_ITER = 24;
   // Accesses plus audio samples over the whole run
   localparam int N_STEPS = 10 + SLOT_ITER * 6 + MAP_ITER * 13 + 8 + AUDIO_ITER;

   logic clk = 1'b0;
   logic cpu_ce = 1'b0;
   logic [1:0] ce_div = 2'd0;
   logic reset, m1_n, mreq_n, iorq_n, rd_n, wr_n, tape_in, ext_wait;
   logic [15:0] addr;
   logic [7:0] cpu_dout, cpu_din, mem_dout;
   logic wait_n, rom_ce, ram_ce;
   logic [MEM_ADDR_W-1:0] mem_addr;
   logic signed [15:0] device_sound;
   logic [15:0] audio;

   // Shadow registers and LFSR state
   logic [7:0] slot_sh;
   logic [7:0] map_sh [4];
   logic click_sh;
   logic [31:0] lfsr = 32'hff;
   // Audio compare pipeline
   logic audio_on;
   logic audio_due = 1'b0;
   logic [15:0] audio_exp;

   always #5 clk = ~clk;

   // CPU clock enable on every fourth clock
   always @(posedge clk) begin
      ce_div <= ce_div + 2'd1;
      cpu_ce <= (ce_div == 2'd3);
   end

   // Memory model
   assign mem_dout = mem_addr[7:0] ^ mem_addr[21:14];

   msx_core #(.M1_WAIT (M1_WAIT), .MEM_ADDR_W (MEM_ADDR_W)) msx_core_i (.*);

   // Galois LFSR stepped once per bit
   function automatic logic [31:0] rnd(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr[0]};
         lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
      end
      return v;
   endfunction

   function automatic logic [1:0] page_slot(input logic [15:0] a);
      return slot_sh[{a[15:14], 1'b0} +: 2];
   endfunction

   function automatic logic [21:0] exp_mem_addr(input logic [15:0] a);
      if (page_slot(a) == RAM_SLOT) begin
         return {map_sh[a[15:14]], a[13:0]};
      end
      return {6'd0, a};
   endfunction

   function automatic logic [7:0] exp_din(input logic rd, input logic [15:0] a);
      logic [1:0] sl;
      logic [21:0] ma;
      sl = page_slot(a);
      ma = exp_mem_addr(a);
      // Empty slots and idle bus float high
      if (!rd || (sl != ROM_SLOT && sl != RAM_SLOT)) begin
         return 8'hFF;
      end
      return ma[7:0] ^ ma[21:14];
   endfunction

   function automatic logic [7:0] exp_io(input logic [7:0] port);
      if (port == PORT_SLOT_SEL) begin
         return slot_sh;
      end else if (port[7:2] == PORT_MAPPER_BASE[7:2]) begin
         return map_sh[port[1:0]];
      end
      return 8'hFF;
   endfunction

   function automatic logic [15:0] exp_audio(input logic click, input logic tape,
         input logic signed [15:0] dev);
      int sum;
      sum = int'(dev) + (click ? 512 : 0) + (tape ? 256 : 0);
      if (sum > 16383) begin
         return 16'h7FFE;
      end else if (sum < -16384) begin
         return 16'h8000;
      end
      return 16'(sum * 2);
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
         $display("Result: FAILED");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   // One CPU bus access held for hold cpu_ce periods plus wait states
   task automatic bus_access(input logic io, input logic rd, input logic m1,
         input logic [15:0] a, input logic [7:0] d, input int hold,
         output logic [7:0] rdata, output int waits);
      int periods;
      logic ready;
      periods = 0;
      waits = 0;
      ready = 1'b0;
      @(posedge clk);
      addr <= a;
      cpu_dout <= d;
      m1_n <= ~m1;
      mreq_n <= io;
      iorq_n <= ~io;
      rd_n <= ~rd;
      wr_n <= rd;
      while (periods < hold || !ready) begin
         @(posedge clk);
         if (cpu_ce) begin
            periods++;
            ready = wait_n;
            if (!wait_n) begin
               waits++;
            end
            // A repeated request in a long write would store this value
            if (periods == 2 && !rd && hold > 2) begin
               cpu_dout <= ~d;
            end
         end
      end
      @(negedge clk);
      rdata = cpu_din;
      check("mem_addr", 32'(mem_addr), 32'(exp_mem_addr(a)));
      check("rom_ce", 32'(rom_ce), 32'(!io && page_slot(a) == ROM_SLOT));
      check("ram_ce", 32'(ram_ce), 32'(!io && page_slot(a) == RAM_SLOT));
      @(posedge clk);
      {mreq_n, iorq_n, rd_n, wr_n, m1_n} <= 5'h1F;
      // Idle until the next cpu_ce
      do begin
         @(posedge clk);
      end while (!cpu_ce);
   endtask

   task automatic mem_read(input logic [15:0] a);
      logic [7:0] d;
      int w;
      bus_access(1'b0, 1'b1, 1'b0, a, 8'h00, HOLD_CE, d, w);
      check("cpu_din", 32'(d), 32'(exp_din(1'b1, a)));
   endtask

   task automatic mem_write(input logic [15:0] a, input logic [7:0] v);
      logic [7:0] d;
      int w;
      bus_access(1'b0, 1'b0, 1'b0, a, v, HOLD_CE, d, w);
      check("cpu_din", 32'(d), 32'(exp_din(1'b0, a)));
   endtask

   task automatic opcode_fetch(input logic [15:0] a);
      logic [7:0] d;
      int w;
      bus_access(1'b0, 1'b1, 1'b1, a, 8'h00, HOLD_CE, d, w);
      check("cpu_din", 32'(d), 32'(exp_din(1'b1, a)));
      check("m1 wait periods", 32'(w), 32'(M1_WAIT));
   endtask

   task automatic io_read(input logic [7:0] port);
      logic [7:0] d;
      int w;
      bus_access(1'b1, 1'b1, 1'b0, {8'(rnd(8)), port}, 8'h00, HOLD_CE, d, w);
      check("cpu_din", 32'(d), 32'(exp_io(port)));
   endtask

   task automatic io_write(input logic [7:0] port, input logic [7:0] v, input logic long_hold);
      logic [7:0] d;
      int w;
      // Register takes the value on req, well before the end of the access
      @(negedge clk);
      if (port == PORT_SLOT_SEL) begin
         slot_sh = v;
      end else if (port[7:2] == PORT_MAPPER_BASE[7:2]) begin
         map_sh[port[1:0]] = v;
      end else if (port == PORT_PPI_C) begin
         click_sh = v[7];
      end
      bus_access(1'b1, 1'b0, 1'b0, {8'(rnd(8)), port}, v, long_hold ? 4 : HOLD_CE, d, w);
   endtask

   // Audio reference one clock behind the inputs
   always @(posedge clk) begin
      audio_exp <= exp_audio(click_sh, tape_in, device_sound);
      audio_due <= audio_on;
   end

   always @(negedge clk) begin
      if (audio_due) begin
         check("audio", 32'(audio), 32'(audio_exp));
      end
   end

   // Watchdog
   initial begin
      repeat (N_STEPS * 40) @(posedge clk);
      $display("Timeout, the test sequence did not finish in %0d clocks", N_STEPS * 40);
      $display("Result: FAILED");
      $fatal(1, "Watchdog expired");
   end

   initial begin
      logic signed [15:0] ds;
      reset <= 1'b1;
      {m1_n, mreq_n, iorq_n, rd_n, wr_n} <= 5'h1F;
      addr <= 16'h0000;
      cpu_dout <= 8'h00;
      tape_in <= 1'b0;
      ext_wait <= 1'b0;
      device_sound <= 16'sd0;
      audio_on <= 1'b0;
      slot_sh = 8'h00;
      click_sh = 1'b0;
      for (int p = 0; p < 4; p++) begin
         map_sh[p] = 8'(3 - p);
      end
      repeat (3) @(posedge clk);
      reset <= 1'b0;

      // Reset values
      io_read(PORT_SLOT_SEL);
      for (int p = 0; p < 4; p++) begin
         io_read(PORT_MAPPER_BASE + 8'(p));
      end

      // Primary slot register, chip enables and empty slots
      for (int i = 0; i < SLOT_ITER; i++) begin
         io_write(PORT_SLOT_SEL, 8'(rnd(8)), i[0]);
         io_read(PORT_SLOT_SEL);
         for (int p = 0; p < 4; p++) begin
            mem_read({2'(p), 14'(rnd(14))});
         end
      end

      // Mapper pages from reset first, then random ones
      io_write(PORT_SLOT_SEL, 8'hFF, 1'b1);
      for (int p = 0; p < 4; p++) begin
         mem_read({2'(p), 14'(rnd(14))});
      end
      for (int i = 0; i < MAP_ITER; i++) begin
         for (int p = 0; p < 4; p++) begin
            io_write(PORT_MAPPER_BASE + 8'(p), 8'(rnd(8)), i[0]);
         end
         for (int p = 0; p < 4; p++) begin
            io_read(PORT_MAPPER_BASE + 8'(p));
            mem_read({2'(p), 14'(rnd(14))});
         end
         mem_write(16'(rnd(16)), 8'(rnd(8)));
      end

      // M1 wait states, then the external wait
      io_write(PORT_SLOT_SEL, 8'(rnd(8)), 1'b0);
      for (int i = 0; i < 4; i++) begin
         opcode_fetch(16'(rnd(16)));
      end
      ext_wait <= 1'b1;
      @(negedge clk);
      check("wait_n", 32'(wait_n), 32'd0);
      @(posedge clk);
      ext_wait <= 1'b0;
      @(negedge clk);
      check("wait_n", 32'(wait_n), 32'd1);

      // Audio with the key click on then off
      for (int half = 0; half < 2; half++) begin
         io_write(PORT_PPI_C, half == 0 ? 8'h80 : 8'h7F, 1'b0);
         audio_on <= 1'b1;
         for (int i = 0; i < AUDIO_ITER / 2; i++) begin
            @(posedge clk);
            ds = 16'(rnd(16));
            if (rnd(1) == 32'd1) begin
               ds = {{3{ds[12]}}, ds[12:0]};
            end
            // Both clip limits
            if (i == 0) begin
               ds = 16'sh7F00;
            end else if (i == 1) begin
               ds = 16'sh8000;
            end
            device_sound <= ds;
            tape_in <= 1'(rnd(1));
         end
         @(posedge clk);
         audio_on <= 1'b0;
      end
      repeat (2) @(posedge clk);

      $display("Result: PASSED");
      $finish;
   end

endmodule

// ==== sources.f ====
rtl/msx_pkg.sv
rtl/cpu_bus_decode.sv
rtl/slot_select.sv
rtl/cpu_data_mux.sv
rtl/audio_mix.sv
rtl/msx_core.sv
tests/msx_core_sva.sv
tests/msx_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the msx_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -f sources.f --top-module msx_core_tb \
      -Mdir obj_dir -o msx_core_sim > build.log 2>&1; then
   cat build.log
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/msx_core_sim > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Result: FAILED" sim.log; then
   exit 1
fi
exit 0
